/* Makefile */
VERILATOR ?= verilator
TOP ?= zxuno_regs_tb
FILELIST ?= zxuno_regs.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
FAIL_MSG = FAIL: see errors above

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/zxuno_regs_sva.sv */
module zxuno_regs_sva #(
    parameter bit CHECK_VIDEO = 1'b0
) (
    input logic clk,
    input logic rst,
    input zxuno_regs_pkg::reg_bus_t bus,
    input zxuno_regs_pkg::video_cfg_t video
);

    // One CPU write cycle gives exactly one strobe
    wr_single_cycle: assert property (@(posedge clk) disable iff (rst) bus.wr |=> !bus.wr)
        else $error("register bus wr strobe held for two cycles");

    // The CPU runs one I/O cycle at a time, so read and write never overlap
    no_rd_with_wr: assert property (@(posedge clk) disable iff (rst) !(bus.rd && bus.wr))
        else $error("bus read and write strobe active together");

    // Only the video block has a control byte to check
    if (CHECK_VIDEO) begin : g_video
        video_cleared: assert property (@(posedge clk) rst |=> (video == 8'h00))
            else $error("video control byte not cleared one cycle after reset");
    end

endmodule

bind zxuno_port zxuno_regs_sva #(.CHECK_VIDEO(1'b0)) port_sva_inst (
    .clk(clk),
    .rst(rst),
    .bus(bus),
    .video('0)
);

bind scandbl_ctrl zxuno_regs_sva #(.CHECK_VIDEO(1'b1)) video_sva_inst (
    .clk(clk),
    .rst(rst),
    .bus(bus),
    .video(video)
);

/* bench/zxuno_regs_tb.sv */
`include "zxuno_regs_defines.svh"

module zxuno_regs_tb;

    import zxuno_regs_pkg::*;

    // Random operations after the directed ones, and the budget that bounds the run
    localparam int N_RANDOM_OPS = 300;
    localparam int MAX_OPS = 400;
    localparam int CYCLES_PER_OP = 12;
    localparam int TIMEOUT_CYCLES = MAX_OPS * CYCLES_PER_OP;

    logic clk;
    logic rst;
    logic [15:0] a;
    logic [7:0] din;
    logic iorq_n;
    logic rd_n;
    logic wr_n;
    logic kbd_change_video_output;
    logic kbd_turbo_boost;
    logic turbo_boost_allowed;
    logic [7:0] cpu_dout;
    logic cpu_oe;
    video_cfg_t video;
    dev_options_t dev;
    joy_conf_t joy;

    // Expected register contents: 0 is video, 1 device options, 2 joystick
    logic [7:0] model_reg [3];
    // Turbo bits the model puts back when the boost key is released
    logic [1:0] model_saved_turbo;

    integer seed;
    int error_count;
    int check_count;
    int cycle_count;

    zxuno_regs zxuno_regs_inst (
        .clk(clk),
        .rst(rst),
        .a(a),
        .din(din),
        .iorq_n(iorq_n),
        .rd_n(rd_n),
        .wr_n(wr_n),
        .kbd_change_video_output(kbd_change_video_output),
        .kbd_turbo_boost(kbd_turbo_boost),
        .turbo_boost_allowed(turbo_boost_allowed),
        .cpu_dout(cpu_dout),
        .cpu_oe(cpu_oe),
        .video(video),
        .dev(dev),
        .joy(joy)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Stops a run that stalls past the longest expected test length
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // Maps a register number to its slot in the model, -1 if unused
    function automatic int reg_index(input logic [7:0] num);
        case (num)
            `REG_SCANDBLCTRL: return 0;
            `REG_DEVOPTIONS: return 1;
            `REG_JOYCONF: return 2;
            default: return -1;
        endcase
    endfunction

    function automatic logic [7:0] pick_reg_num(input logic [1:0] sel, input logic [7:0] other);
        case (sel)
            2'd0: return `REG_SCANDBLCTRL;
            2'd1: return `REG_DEVOPTIONS;
            2'd2: return `REG_JOYCONF;
            default: begin
                // All used numbers sit below 8'h80, so flipping the top bit leaves the map
                if (reg_index(other) >= 0) begin
                    return other ^ 8'h80;
                end
                return other;
            end
        endcase
    endfunction

    // VGA toggles; on selects refresh option 7, off drops back to option 0
    function automatic logic [7:0] after_video_key(input logic [7:0] cur);
        video_cfg_t v;
        v = video_cfg_t'(cur);
        v.vga = !v.vga;
        v.freq = v.vga ? 3'd7 : 3'd0;
        return v;
    endfunction

    task automatic check_byte(input string test, input string what,
                              input logic [7:0] expected, input logic [7:0] actual);
        check_count++;
        if (actual !== expected) begin
            $display("Fail %s %s: expected %h, actual %h", test, what, expected, actual);
            error_count++;
        end
    endtask

    // All payload outputs against the model; the read path must be idle
    task automatic check_outputs(input string test);
        check_byte(test, "video", model_reg[0], video);
        check_byte(test, "dev", model_reg[1], dev);
        check_byte(test, "joy", model_reg[2], joy);
        check_byte(test, "idle cpu_oe", 8'h00, {7'h00, cpu_oe});
    endtask

    // One CPU I/O cycle of 3 clocks followed by 2 idle clocks, starting on a falling edge
    task automatic io_cycle(input logic [15:0] addr, input logic [7:0] data,
                            input logic is_write, output logic [7:0] dout_seen,
                            output logic oe_seen);
        a = addr;
        din = data;
        iorq_n = 1'b0;
        wr_n = !is_write;
        rd_n = is_write;
        repeat (3) @(negedge clk);
        // Read path is sampled before the strobes drop
        dout_seen = cpu_dout;
        oe_seen = cpu_oe;
        iorq_n = 1'b1;
        rd_n = 1'b1;
        wr_n = 1'b1;
        a = 16'h0000;
        din = 8'h00;
        repeat (2) @(negedge clk);
    endtask

    task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
        logic [7:0] unused_dout;
        logic unused_oe;
        io_cycle(addr, data, 1'b1, unused_dout, unused_oe);
    endtask

    // Data-port read of the register already selected by the address latch
    task automatic read_data(input string test, input logic [7:0] num);
        int idx;
        logic [7:0] seen;
        logic oe;
        idx = reg_index(num);
        io_cycle(`ZXUNO_DATA_PORT, 8'h00, 1'b0, seen, oe);
        if (idx >= 0) begin
            check_byte(test, "cpu_dout", model_reg[idx[1:0]], seen);
            check_byte(test, "cpu_oe", 8'h01, {7'h00, oe});
        end else begin
            // Nobody answers, so the bus floats high
            check_byte(test, "cpu_dout", 8'hFF, seen);
            check_byte(test, "cpu_oe", 8'h00, {7'h00, oe});
        end
    endtask

    task automatic read_reg(input string test, input logic [7:0] num);
        io_write(`ZXUNO_ADDR_PORT, num);
        read_data(test, num);
    endtask

    task automatic write_reg(input string test, input logic [7:0] num, input logic [7:0] data);
        int idx;
        idx = reg_index(num);
        io_write(`ZXUNO_ADDR_PORT, num);
        io_write(`ZXUNO_DATA_PORT, data);
        if (idx >= 0) begin
            model_reg[idx[1:0]] = data;
        end
        check_outputs(test);
        read_data(test, num);
    endtask

    // Legacy port writes only the two turbo bits
    task automatic speed_write(input logic [7:0] data);
        video_cfg_t v;
        io_write(`PRISM_SPEED_PORT, data);
        v = video_cfg_t'(model_reg[0]);
        v.turbo = data[1:0];
        model_reg[0] = v;
        check_outputs("speed_port");
    endtask

    task automatic video_key_press();
        kbd_change_video_output = 1'b1;
        model_reg[0] = after_video_key(model_reg[0]);
        repeat (4) @(negedge clk);
        check_outputs("video_key");
        // Release edge does nothing
        kbd_change_video_output = 1'b0;
        repeat (4) @(negedge clk);
        check_outputs("video_key");
    endtask

    task automatic turbo_key_press();
        video_cfg_t v;
        kbd_turbo_boost = 1'b1;
        v = video_cfg_t'(model_reg[0]);
        model_saved_turbo = v.turbo;
        v.turbo = 2'b11;
        model_reg[0] = v;
        repeat (4) @(negedge clk);
        check_outputs("turbo_key");
        kbd_turbo_boost = 1'b0;
        v.turbo = model_saved_turbo;
        model_reg[0] = v;
        repeat (4) @(negedge clk);
        check_outputs("turbo_key");
    endtask

    // With boost not allowed, a full press and release leaves every register alone
    task automatic turbo_key_blocked();
        turbo_boost_allowed = 1'b0;
        @(negedge clk);
        kbd_turbo_boost = 1'b1;
        repeat (4) @(negedge clk);
        check_outputs("turbo_blocked");
        kbd_turbo_boost = 1'b0;
        repeat (4) @(negedge clk);
        check_outputs("turbo_blocked");
        turbo_boost_allowed = 1'b1;
        @(negedge clk);
    endtask

    initial begin
        logic [31:0] rnd;
        logic [7:0] num;
        seed = 32'h5095;
        error_count = 0;
        check_count = 0;
        rst = 1'b1;
        a = 16'h0000;
        din = 8'h00;
        iorq_n = 1'b1;
        rd_n = 1'b1;
        wr_n = 1'b1;
        kbd_change_video_output = 1'b0;
        kbd_turbo_boost = 1'b0;
        turbo_boost_allowed = 1'b1;
        model_reg[0] = 8'h00;
        model_reg[1] = `RESET_DEVOPTIONS;
        model_reg[2] = `RESET_JOYCONF;
        model_saved_turbo = 2'b00;
        repeat (10) @(negedge clk);
        rst = 1'b0;

        // Reset state, then each feature once before the random mix
        check_outputs("reset");
        read_reg("reset", `REG_SCANDBLCTRL);
        read_reg("reset", `REG_DEVOPTIONS);
        read_reg("reset", `REG_JOYCONF);
        read_reg("unused_reg", 8'h00);
        speed_write(8'h02);
        video_key_press();
        video_key_press();
        turbo_key_press();
        turbo_key_blocked();

        for (int i = 0; i < N_RANDOM_OPS; i++) begin
            rnd = $random(seed);
            num = pick_reg_num(rnd[9:8], rnd[23:16]);
            case (rnd[2:0])
                3'd0, 3'd1: write_reg("readback", num, rnd[31:24]);
                3'd2, 3'd3: read_reg("readback", num);
                3'd4: speed_write(rnd[31:24]);
                3'd5: video_key_press();
                3'd6: turbo_key_press();
                default: turbo_key_blocked();
            endcase
        end

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* verilog/cfg_reg.sv */
module cfg_reg #(
    parameter type payload_t = logic [7:0],
    parameter logic [7:0] REG_ADDR = 8'h00,
    parameter logic [7:0] RESET_VAL = 8'h00
) (
    input  logic clk,
    input  logic rst,
    input  zxuno_regs_pkg::reg_bus_t bus,
    output zxuno_regs_pkg::peer_rd_t rd_resp,
    output payload_t value
);

    // Registered copy of the payload for the read path
    logic [7:0] dout_q;
    // This block is the target of the current bus cycle
    logic hit;

    assign hit = (bus.addr == REG_ADDR);

    // Payload is a plain byte on the bus, so the write data is
    // reinterpreted as the structured type
    always_ff @(posedge clk) begin
        if (rst) begin
            value <= payload_t'(RESET_VAL);
        end else if (bus.wr && hit) begin
            value <= payload_t'(bus.wdata);
        end
    end

    always_ff @(posedge clk) begin
        dout_q <= 8'(value);
    end

    // Answer only while a read of this register number is active
    always_comb begin
        rd_resp.oe = bus.rd && hit;
        rd_resp.data = dout_q;
    end

endmodule

/* verilog/reg_read_select.sv */
module reg_read_select #(
    parameter int N_PEERS = 3
) (
    input  zxuno_regs_pkg::peer_rd_t peers [N_PEERS],
    output logic [7:0] cpu_dout,
    output logic cpu_oe
);

    // Lowest index wins; the loop runs downwards so that a later
    // assignment from a lower index overrides a higher one
    // Register numbers are distinct, so two answers at once only
    // happen if a block is instantiated with a clashing address
    always_comb begin
        // Open bus reads back as all ones, like an undriven Z80 data bus
        cpu_dout = 8'hFF;
        cpu_oe = 1'b0;
        for (int i = N_PEERS - 1; i >= 0; i--) begin
            if (peers[i].oe) begin
                cpu_dout = peers[i].data;
                cpu_oe = 1'b1;
            end
        end
    end

endmodule

/* verilog/scandbl_ctrl.sv */
`include "zxuno_regs_defines.svh"

module scandbl_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic [15:0] a,
    input  logic [7:0] din,
    input  logic iorq_n,
    input  logic wr_n,
    input  logic kbd_change_video_output,
    input  logic kbd_turbo_boost,
    input  logic turbo_boost_allowed,
    input  zxuno_regs_pkg::reg_bus_t bus,
    output zxuno_regs_pkg::peer_rd_t rd_resp,
    output zxuno_regs_pkg::video_cfg_t video
);

    // Two-stage shift registers for the hotkey edge detectors
    logic [1:0] video_key_sr;
    logic [1:0] turbo_key_sr;
    // Turbo key level, frozen while boosting is not allowed
    logic turbo_key_gated;
    // Turbo bits in force before the boost key went down
    logic [1:0] saved_turbo;
    // Registered decode of a write to the legacy speed port
    logic spd_wr_q;
    logic [1:0] spd_din_q;
    // Copy of the control byte returned on reads
    logic [7:0] dout_q;

    // Key held while not allowed is ignored, the last level is kept
    always_ff @(posedge clk) begin
        if (rst) begin
            turbo_key_gated <= 1'b0;
        end else if (turbo_boost_allowed) begin
            turbo_key_gated <= kbd_turbo_boost;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            video_key_sr <= 2'b00;
            turbo_key_sr <= 2'b00;
            saved_turbo <= 2'b00;
            spd_wr_q <= 1'b0;
            spd_din_q <= 2'b00;
            video <= '0;
        end else begin
            video_key_sr <= {video_key_sr[0], kbd_change_video_output};
            turbo_key_sr <= {turbo_key_sr[0], turbo_key_gated};
            spd_wr_q <= !iorq_n && !wr_n && (a == `PRISM_SPEED_PORT);
            spd_din_q <= din[1:0];
            // Sources in priority order, highest first
            if (bus.wr && (bus.addr == `REG_SCANDBLCTRL)) begin
                video <= bus.wdata;
            end else if (spd_wr_q) begin
                video.turbo <= spd_din_q;
            end else if (video_key_sr == 2'b01) begin
                // VGA on selects the top refresh option, off returns to 50 Hz
                video.freq <= video.vga ? 3'd0 : 3'd7;
                video.vga <= !video.vga;
            end else if (turbo_key_sr == 2'b01) begin
                saved_turbo <= video.turbo;
                video.turbo <= 2'b11;
            end else if (turbo_key_sr == 2'b10) begin
                video.turbo <= saved_turbo;
            end
        end
    end

    always_ff @(posedge clk) begin
        dout_q <= video;
    end

    always_comb begin
        rd_resp.oe = bus.rd && (bus.addr == `REG_SCANDBLCTRL);
        rd_resp.data = dout_q;
    end

endmodule

/* verilog/zxuno_port.sv */
`include "zxuno_regs_defines.svh"

module zxuno_port (
    input  logic clk,
    input  logic rst,
    input  logic [15:0] a,
    input  logic [7:0] din,
    input  logic iorq_n,
    input  logic rd_n,
    input  logic wr_n,
    output zxuno_regs_pkg::reg_bus_t bus
);

    // An I/O write is in progress while both strobes are low
    logic io_wr;
    // Level of io_wr seen at the previous edge
    logic io_wr_q;
    // First sampled cycle of a CPU write
    logic wr_start;

    // Register number selected through the address port
    logic [7:0] reg_addr;
    // Byte taken from the CPU at the start of a data-port write
    logic [7:0] wdata_q;
    // One-cycle write strobe towards the register blocks
    logic wr_q;

    assign io_wr = !iorq_n && !wr_n;

    // A CPU cycle holds its strobes for several clocks, so only the
    // first sampled clock of each cycle counts
    assign wr_start = io_wr && !io_wr_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            io_wr_q <= 1'b0;
            reg_addr <= 8'h00;
            wr_q <= 1'b0;
        end else begin
            io_wr_q <= io_wr;
            wr_q <= wr_start && (a == `ZXUNO_DATA_PORT);
            if (wr_start && (a == `ZXUNO_ADDR_PORT)) begin
                reg_addr <= din;
            end
        end
    end

    // Write data is payload, captured with the strobe
    always_ff @(posedge clk) begin
        if (wr_start) begin
            wdata_q <= din;
        end
    end

    // Read level is not registered so that cpu_oe tracks the CPU cycle
    always_comb begin
        bus.addr = reg_addr;
        bus.wdata = wdata_q;
        bus.rd = !iorq_n && !rd_n && (a == `ZXUNO_DATA_PORT);
        bus.wr = wr_q;
    end

endmodule

/* verilog/zxuno_regs.sv */
`include "zxuno_regs_defines.svh"

module zxuno_regs (
    input  logic clk,
    input  logic rst,
    input  logic [15:0] a,
    input  logic [7:0] din,
    input  logic iorq_n,
    input  logic rd_n,
    input  logic wr_n,
    input  logic kbd_change_video_output,
    input  logic kbd_turbo_boost,
    input  logic turbo_boost_allowed,
    output logic [7:0] cpu_dout,
    output logic cpu_oe,
    output zxuno_regs_pkg::video_cfg_t video,
    output zxuno_regs_pkg::dev_options_t dev,
    output zxuno_regs_pkg::joy_conf_t joy
);

    import zxuno_regs_pkg::*;

    // Shared register bus driven by the port decoder
    reg_bus_t bus;
    // Read answers: scandoubler control first, then options, then joystick
    peer_rd_t peers [3];

    zxuno_port zxuno_port_inst (
        .clk(clk),
        .rst(rst),
        .a(a),
        .din(din),
        .iorq_n(iorq_n),
        .rd_n(rd_n),
        .wr_n(wr_n),
        .bus(bus)
    );

    // Also snoops the raw CPU write for the older speed port
    scandbl_ctrl scandbl_ctrl_inst (
        .clk(clk),
        .rst(rst),
        .a(a),
        .din(din),
        .iorq_n(iorq_n),
        .wr_n(wr_n),
        .kbd_change_video_output(kbd_change_video_output),
        .kbd_turbo_boost(kbd_turbo_boost),
        .turbo_boost_allowed(turbo_boost_allowed),
        .bus(bus),
        .rd_resp(peers[0]),
        .video(video)
    );

    cfg_reg #(
        .payload_t(dev_options_t),
        .REG_ADDR(`REG_DEVOPTIONS),
        .RESET_VAL(`RESET_DEVOPTIONS)
    ) dev_options_inst (
        .clk(clk),
        .rst(rst),
        .bus(bus),
        .rd_resp(peers[1]),
        .value(dev)
    );

    cfg_reg #(
        .payload_t(joy_conf_t),
        .REG_ADDR(`REG_JOYCONF),
        .RESET_VAL(`RESET_JOYCONF)
    ) joy_conf_inst (
        .clk(clk),
        .rst(rst),
        .bus(bus),
        .rd_resp(peers[2]),
        .value(joy)
    );

    reg_read_select #(
        .N_PEERS(3)
    ) reg_read_select_inst (
        .peers(peers),
        .cpu_dout(cpu_dout),
        .cpu_oe(cpu_oe)
    );

endmodule

/* verilog/zxuno_regs_defines.svh */
`ifndef ZXUNO_REGS_DEFINES_SVH
`define ZXUNO_REGS_DEFINES_SVH

// CPU I/O port addresses, all decoded on the full 16-bit address

// Selects the register number for the following data-port access
`define ZXUNO_ADDR_PORT 16'hFC3B

// Reads or writes the register picked through the address port
`define ZXUNO_DATA_PORT 16'hFD3B

// Older speed-control port, which writes the turbo bits only
`define PRISM_SPEED_PORT 16'h8E3B

// Register numbers on the shared register bus
`define REG_SCANDBLCTRL 8'h0B
`define REG_DEVOPTIONS 8'h0E
`define REG_JOYCONF 8'h06

// Power-up contents of the generic configuration registers
`define RESET_DEVOPTIONS 8'h00
`define RESET_JOYCONF 8'h00

`endif

/* verilog/zxuno_regs_pkg.sv */
package zxuno_regs_pkg;

    // Register bus from the port decoder to every register block
    // Only wr is a strobe; rd stays high for the whole data-port read
    typedef struct packed {
        logic [7:0] addr;
        logic [7:0] wdata;
        logic rd;
        logic wr;
    } reg_bus_t;

    // Scandoubler and speed control byte, most significant field first
    typedef struct packed {
        logic [1:0] turbo;
        logic csync;
        logic [2:0] freq;
        logic scanlines;
        logic vga;
    } video_cfg_t;

    // Each flag set to one switches the matching device off
    typedef struct packed {
        logic disable_kempston;
        logic disable_ay;
        logic disable_turbo_ay;
        logic disable_7ffd;
        logic disable_1ffd;
        logic disable_rom_paging;
        logic disable_ulaplus;
        logic disable_timex;
    } dev_options_t;

    // Joystick setup, keyboard-mapped joystick in the top nibble
    typedef struct packed {
        logic [2:0] kempston_mode;
        logic autofire;
        logic [2:0] db9_mode;
        logic autofire2;
    } joy_conf_t;

    // Read answer from one register block to the read-return selector
    typedef struct packed {
        logic oe;
        logic [7:0] data;
    } peer_rd_t;

endpackage

/* zxuno_regs.f */
+incdir+verilog
verilog/zxuno_regs_pkg.sv
verilog/zxuno_port.sv
verilog/scandbl_ctrl.sv
verilog/cfg_reg.sv
verilog/reg_read_select.sv
verilog/zxuno_regs.sv
bench/zxuno_regs_sva.sv
bench/zxuno_regs_tb.sv
